/* flist.f */
+incdir+verilog
+incdir+verif
verilog/comp_pkg.sv
verilog/comp_hdr_decode.sv
verilog/comp_payload_fifo.sv
verilog/comp_cpl_builder.sv
verilog/comp_unit.sv
verif/tb_clk_gen.sv
verif/tb_comp_unit.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_comp_unit
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_comp_tasks.svh */
`ifndef TB_COMP_TASKS_SVH
`define TB_COMP_TASKS_SVH

   localparam logic [31:0] RNG_SEED = 32'd91072;

   int                 val_errs = 0;
   int                 other_errs = 0;
   int                 eof_seen = 0;
   logic               bp_en = 1'b0;
   logic [31:0]        bp_rng = RNG_SEED;
   logic [31:0]        data_rng = RNG_SEED ^ 32'h9E37_79B9;
   comp_pkg::ll_word_t pay[$];
   // flag queues hold {sof_n, eof_n, sop_n, eop_n}
   comp_pkg::ll_word_t rx_d_q[$];
   comp_pkg::ll_rem_t  rx_rem_q[$];
   logic [3:0]         rx_flag_q[$];
   comp_pkg::ll_word_t exp_d_q[$];
   comp_pkg::ll_rem_t  exp_rem_q[$];
   logic [3:0]         exp_flag_q[$];

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_word(input string name, input comp_pkg::ll_word_t exp,
                             input comp_pkg::ll_word_t act);
      if (act !== exp) begin
         val_errs++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_rem(input string name, input comp_pkg::ll_rem_t exp,
                            input comp_pkg::ll_rem_t act);
      if (act !== exp) begin
         val_errs++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         val_errs++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // rx sink, accepts a word whenever both ready flags are low
   initial begin : rx_sink
      rx_dst_rdy_n = 1'b0;
      forever begin
         // ready flags hold from the falling edge to the next rising edge
         @(negedge clk);
         if (rst_n && !rx_src_rdy_n && !rx_dst_rdy_n) begin
            rx_d_q.push_back(rx_d);
            rx_rem_q.push_back(rx_rem);
            rx_flag_q.push_back({rx_sof_n, rx_eof_n, rx_sop_n, rx_eop_n});
            if (!rx_eof_n) begin
               eof_seen++;
            end
         end
         @(posedge clk);
         if (bp_en) begin
            bp_rng = xorshift32(bp_rng);
            rx_dst_rdy_n <= bp_rng[4];
         end else begin
            rx_dst_rdy_n <= 1'b0;
         end
      end
   end

   task automatic fill_payload(input int n);
      pay.delete();
      for (int i = 0; i < n; i++) begin
         data_rng = xorshift32(data_rng);
         pay.push_back(data_rng);
      end
   endtask

   // low bytes dropped by rem on the eop word
   function automatic int invalid_bytes(input comp_pkg::ll_rem_t rem);
      case (rem)
         4'b0001: return 1;
         4'b0011: return 2;
         4'b0111: return 3;
         default: return 0;
      endcase
   endfunction

   task automatic send_frame(input comp_pkg::comp_op_e op, input comp_pkg::byte_cnt_t len,
                             input comp_pkg::task_idx_t tidx, input comp_pkg::ll_rem_t last_rem);
      comp_pkg::ll_word_t hdr[`COMP_HDR_WORDS];
      int                 npay;
      int                 nw;
      logic               stalled;
      npay = pay.size();
      nw   = `COMP_HDR_WORDS + npay;
      for (int i = 0; i < `COMP_HDR_WORDS; i++) begin
         data_rng = xorshift32(data_rng);
         hdr[i]   = data_rng;
      end
      // random bits around the fields
      hdr[`COMP_HDR_FLAG_IDX][`COMP_DW-1 -: 3]    = op;
      hdr[`COMP_HDR_LEN_IDX]                      = len;
      hdr[`COMP_HDR_TASK_IDX][`COMP_TASK_W-1:0]   = tidx;
      @(posedge clk);
      for (int i = 0; i < nw; i++) begin
         if (i < `COMP_HDR_WORDS) begin
            tx_d <= hdr[i];
         end else begin
            tx_d <= pay[i - `COMP_HDR_WORDS];
         end
         tx_rem       <= (i == nw - 1 && npay != 0) ? last_rem : 4'b0000;
         tx_sof_n     <= (i != 0);
         tx_eof_n     <= (i != nw - 1);
         tx_sop_n     <= (i != `COMP_HDR_WORDS);
         tx_eop_n     <= (i != nw - 1) || (npay == 0);
         tx_src_rdy_n <= 1'b0;
         // dst ready seen at the falling edge holds through the next rising edge
         do begin
            @(negedge clk);
            stalled = tx_dst_rdy_n;
            @(posedge clk);
         end while (stalled);
      end
      tx_src_rdy_n <= 1'b1;
      tx_sof_n     <= 1'b1;
      tx_eof_n     <= 1'b1;
      tx_sop_n     <= 1'b1;
      tx_eop_n     <= 1'b1;
   endtask

`endif

/* verif/tb_comp_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "comp_consts.svh"

module tb_comp_unit;

   localparam int HW = `COMP_HDR_WORDS;
   // tx words of every frame sent, header plus payload
   localparam int FRAME_WORDS = 6 * HW + 5 + 4 + 3 + 4 + 40 + 6;
   localparam int WATCHDOG_CYCLES = FRAME_WORDS * 50;

   logic                clk;
   logic                rst_n;
   comp_pkg::ll_word_t  tx_d;
   comp_pkg::ll_rem_t   tx_rem;
   logic                tx_sof_n;
   logic                tx_eof_n;
   logic                tx_sop_n;
   logic                tx_eop_n;
   logic                tx_src_rdy_n;
   logic                tx_dst_rdy_n;
   comp_pkg::ll_word_t  rx_d;
   comp_pkg::ll_rem_t   rx_rem;
   logic                rx_sof_n;
   logic                rx_eof_n;
   logic                rx_sop_n;
   logic                rx_eop_n;
   logic                rx_src_rdy_n;
   logic                rx_dst_rdy_n;

   tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) u_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   comp_unit u_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d),
      .tx_rem_i       (tx_rem),
      .tx_sof_n_i     (tx_sof_n),
      .tx_eof_n_i     (tx_eof_n),
      .tx_sop_n_i     (tx_sop_n),
      .tx_eop_n_i     (tx_eop_n),
      .tx_src_rdy_n_i (tx_src_rdy_n),
      .tx_dst_rdy_n_o (tx_dst_rdy_n),
      .rx_d_o         (rx_d),
      .rx_rem_o       (rx_rem),
      .rx_sof_n_o     (rx_sof_n),
      .rx_eof_n_o     (rx_eof_n),
      .rx_sop_n_o     (rx_sop_n),
      .rx_eop_n_o     (rx_eop_n),
      .rx_src_rdy_n_o (rx_src_rdy_n),
      .rx_dst_rdy_n_i (rx_dst_rdy_n)
   );

   `include "tb_comp_tasks.svh"

   // expected rx words: payload for copy only, then three trailer words
   task automatic queue_expected(input comp_pkg::comp_op_e op, input comp_pkg::byte_cnt_t len,
                                 input comp_pkg::task_idx_t tidx,
                                 input comp_pkg::ll_rem_t last_rem);
      comp_pkg::ll_word_t  trl0;
      comp_pkg::byte_cnt_t cnt;
      int                  npay;
      int                  nb;
      cnt  = '0;
      npay = (op == comp_pkg::OP_COPY) ? pay.size() : 0;
      for (int i = 0; i < npay; i++) begin
         nb  = (i == npay - 1) ? invalid_bytes(last_rem) : 0;
         cnt = cnt + comp_pkg::byte_cnt_t'(4 - nb);
         exp_d_q.push_back(pay[i] & ({`COMP_DW{1'b1}} << (8 * nb)));
         exp_rem_q.push_back((i == npay - 1) ? last_rem : 4'b0000);
         exp_flag_q.push_back({(i != 0), 1'b1, (i != 0), (i != npay - 1)});
      end
      trl0 = '0;
      trl0[`COMP_DW-1 -: 3]     = op;
      trl0[`COMP_STATUS_BIT]    = (op == comp_pkg::OP_COPY) && (cnt == len);
      exp_d_q.push_back(trl0);
      exp_d_q.push_back(cnt);
      exp_d_q.push_back({{(`COMP_DW - `COMP_TASK_W){1'b0}}, tidx});
      repeat (3) exp_rem_q.push_back(4'b0000);
      exp_flag_q.push_back({(npay != 0), 3'b111});
      exp_flag_q.push_back(4'b1111);
      exp_flag_q.push_back(4'b1011);
   endtask

   task automatic wait_eof(input int target, input string name, input int max_cycles);
      int waited;
      waited = 0;
      while (eof_seen < target && waited < max_cycles) begin
         @(posedge clk);
         waited++;
      end
      if (eof_seen < target) begin
         other_errs++;
         $display("%s: no end of frame on RX within %0d cycles", name, max_cycles);
      end
   endtask

   // pops one expected frame, up to its eof word
   task automatic compare_frame(input string name);
      comp_pkg::ll_word_t ew;
      comp_pkg::ll_word_t aw;
      comp_pkg::ll_rem_t  er;
      comp_pkg::ll_rem_t  ar;
      logic [3:0]         ef;
      logic [3:0]         af;
      logic               done;
      int                 idx;
      string              tag;
      done = 1'b0;
      idx  = 0;
      while (!done && exp_d_q.size() != 0) begin
         ew   = exp_d_q.pop_front();
         er   = exp_rem_q.pop_front();
         ef   = exp_flag_q.pop_front();
         done = !ef[2];
         tag  = $sformatf("%s word %0d", name, idx);
         if (rx_d_q.size() == 0) begin
            other_errs++;
            $display("%s: word missing from RX frame", tag);
         end else begin
            aw = rx_d_q.pop_front();
            ar = rx_rem_q.pop_front();
            af = rx_flag_q.pop_front();
            check_word({tag, " data"}, ew, aw);
            check_rem({tag, " rem"}, er, ar);
            check_flag({tag, " sof_n"}, ef[3], af[3]);
            check_flag({tag, " eof_n"}, ef[2], af[2]);
            check_flag({tag, " sop_n"}, ef[1], af[1]);
            check_flag({tag, " eop_n"}, ef[0], af[0]);
         end
         idx++;
      end
   endtask

   task automatic run_frame(input string name, input comp_pkg::comp_op_e op,
                            input comp_pkg::byte_cnt_t len, input comp_pkg::task_idx_t tidx,
                            input int npay, input comp_pkg::ll_rem_t last_rem);
      int base;
      base = eof_seen;
      fill_payload(npay);
      queue_expected(op, len, tidx, last_rem);
      send_frame(op, len, tidx, last_rem);
      wait_eof(base + 1, name, 50 * (HW + npay));
      compare_frame(name);
   endtask

   task automatic idle_after_reset();
      @(negedge clk);
      check_flag("idle_after_reset rx_src_rdy_n", 1'b1, rx_src_rdy_n);
      check_flag("idle_after_reset tx_dst_rdy_n", 1'b0, tx_dst_rdy_n);
   endtask

   // 40 words overrun the 16-entry buffer while rx stalls
   task automatic copy_under_backpressure();
      int base;
      base  = eof_seen;
      bp_en = 1'b1;
      fill_payload(40);
      queue_expected(comp_pkg::OP_COPY, 32'd160, 10'h3FF, 4'b0000);
      send_frame(comp_pkg::OP_COPY, 32'd160, 10'h3FF, 4'b0000);
      fill_payload(6);
      queue_expected(comp_pkg::OP_COPY, 32'd21, 10'h001, 4'b0111);
      send_frame(comp_pkg::OP_COPY, 32'd21, 10'h001, 4'b0111);
      wait_eof(base + 2, "copy_under_backpressure", 50 * (2 * HW + 46));
      compare_frame("copy_under_backpressure first");
      compare_frame("copy_under_backpressure second");
      bp_en = 1'b0;
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, %0d value errors, %0d other errors",
               WATCHDOG_CYCLES, val_errs, other_errs);
      $display("Regression failed");
      $finish;
   end

   initial begin : main_seq
      tx_d         = '0;
      tx_rem       = '0;
      tx_sof_n     = 1'b1;
      tx_eof_n     = 1'b1;
      tx_sop_n     = 1'b1;
      tx_eop_n     = 1'b1;
      tx_src_rdy_n = 1'b1;
      wait (rst_n === 1'b1);
      idle_after_reset();
      run_frame("copy_full_words", comp_pkg::OP_COPY, 32'd20, 10'h2A5, 5, 4'b0000);
      run_frame("copy_partial_last", comp_pkg::OP_COPY, 32'd14, 10'h13C, 4, 4'b0011);
      run_frame("copy_length_mismatch", comp_pkg::OP_COPY, 32'd16, 10'h07E, 3, 4'b0000);
      run_frame("comp_op_discard", comp_pkg::OP_COMP, 32'd16, 10'h2C1, 4, 4'b0000);
      copy_under_backpressure();
      repeat (5) @(negedge clk);
      if (rx_d_q.size() != 0) begin
         other_errs++;
         $display("%0d unexpected words left on RX", rx_d_q.size());
      end
      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs + other_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset drops on a rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

/* verilog/comp_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module comp_unit (
   input  wire                   clk,
   input  wire                   rst_n,
   // tx port, frames from the dma engine
   input  wire comp_pkg::ll_word_t tx_d_i,
   input  wire comp_pkg::ll_rem_t  tx_rem_i,
   input  wire                   tx_sof_n_i,
   input  wire                   tx_eof_n_i,
   input  wire                   tx_sop_n_i,
   input  wire                   tx_eop_n_i,
   input  wire                   tx_src_rdy_n_i,
   output logic                  tx_dst_rdy_n_o,
   // rx port, payload plus completion
   output comp_pkg::ll_word_t    rx_d_o,
   output comp_pkg::ll_rem_t     rx_rem_o,
   output logic                  rx_sof_n_o,
   output logic                  rx_eof_n_o,
   output logic                  rx_sop_n_o,
   output logic                  rx_eop_n_o,
   output logic                  rx_src_rdy_n_o,
   input  wire                   rx_dst_rdy_n_i
);

   logic                 wr_en;
   comp_pkg::ll_word_t   wr_data;
   comp_pkg::ll_rem_t    wr_rem;
   logic                 wr_last;
   logic                 full;
   logic                 rd_en;
   comp_pkg::ll_word_t   rd_data;
   comp_pkg::ll_rem_t    rd_rem;
   logic                 rd_last;
   logic                 empty;
   logic                 info_valid;
   comp_pkg::comp_op_e   op;
   logic                 status;
   comp_pkg::byte_cnt_t  byte_cnt;
   comp_pkg::task_idx_t  task_idx;
   logic                 cpl_done;

   comp_hdr_decode u_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_sop_n_i     (tx_sop_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .full_i         (full),
      .cpl_done_i     (cpl_done),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .wr_en_o        (wr_en),
      .wr_data_o      (wr_data),
      .wr_rem_o       (wr_rem),
      .wr_last_o      (wr_last),
      .info_valid_o   (info_valid),
      .op_o           (op),
      .status_o       (status),
      .byte_cnt_o     (byte_cnt),
      .task_idx_o     (task_idx)
   );

   comp_payload_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .wr_rem_i  (wr_rem),
      .wr_last_i (wr_last),
      .rd_en_i   (rd_en),
      .full_o    (full),
      .empty_o   (empty),
      .rd_data_o (rd_data),
      .rd_rem_o  (rd_rem),
      .rd_last_o (rd_last)
   );

   comp_cpl_builder u_builder (
      .clk            (clk),
      .rst_n          (rst_n),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .empty_i        (empty),
      .rd_data_i      (rd_data),
      .rd_rem_i       (rd_rem),
      .rd_last_i      (rd_last),
      .info_valid_i   (info_valid),
      .op_i           (op),
      .status_i       (status),
      .byte_cnt_i     (byte_cnt),
      .task_idx_i     (task_idx),
      .rd_en_o        (rd_en),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .cpl_done_o     (cpl_done)
   );

endmodule

`default_nettype wire

/* verilog/comp_cpl_builder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "comp_consts.svh"

module comp_cpl_builder (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      rx_dst_rdy_n_i,
   input  wire                      empty_i,
   input  wire comp_pkg::ll_word_t  rd_data_i,
   input  wire comp_pkg::ll_rem_t   rd_rem_i,
   input  wire                      rd_last_i,
   input  wire                      info_valid_i,
   input  wire comp_pkg::comp_op_e  op_i,
   input  wire                      status_i,
   input  wire comp_pkg::byte_cnt_t byte_cnt_i,
   input  wire comp_pkg::task_idx_t task_idx_i,
   output logic                     rd_en_o,
   output comp_pkg::ll_word_t       rx_d_o,
   output comp_pkg::ll_rem_t        rx_rem_o,
   output logic                     rx_sof_n_o,
   output logic                     rx_eof_n_o,
   output logic                     rx_sop_n_o,
   output logic                     rx_eop_n_o,
   output logic                     rx_src_rdy_n_o,
   output logic                     cpl_done_o
);

   comp_pkg::cpl_state_e state_q;
   logic                 info_pend_q;
   logic                 sop_pend_q;
   comp_pkg::comp_op_e   op_q;
   logic                 status_q;
   comp_pkg::byte_cnt_t  cnt_q;
   comp_pkg::task_idx_t  task_q;
   logic                 rx_xfer;
   logic                 load;
   logic                 in_stream;
   logic                 take_payload;
   logic                 take_trl0;
   comp_pkg::ll_word_t   trl0_word;

   // output register is free when empty or being accepted this cycle
   assign rx_xfer   = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   assign load      = rx_src_rdy_n_o || !rx_dst_rdy_n_i;
   assign in_stream = (state_q == comp_pkg::CPL_IDLE) || (state_q == comp_pkg::CPL_PAYLOAD);

   // payload first, trailer only after the buffer drained
   assign take_payload = load && in_stream && !empty_i;
   assign take_trl0    = load && in_stream && empty_i && info_pend_q;

   assign rd_en_o    = take_payload;
   assign cpl_done_o = rx_xfer && (state_q == comp_pkg::CPL_TRL2);

   always_comb begin
      trl0_word = '0;
      trl0_word[`COMP_DW-1 -: $bits(comp_pkg::comp_op_e)] = op_q;
      trl0_word[`COMP_STATUS_BIT] = status_q;
   end

   // frame info, held until TRL2 leaves
   always_ff @(posedge clk) begin
      if (info_valid_i) begin
         op_q     <= op_i;
         status_q <= status_i;
         cnt_q    <= byte_cnt_i;
         task_q   <= task_idx_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q        <= comp_pkg::CPL_IDLE;
         info_pend_q    <= 1'b0;
         sop_pend_q     <= 1'b1;
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o     <= 1'b1;
         rx_eof_n_o     <= 1'b1;
         rx_sop_n_o     <= 1'b1;
         rx_eop_n_o     <= 1'b1;
      end else begin
         if (info_valid_i) begin
            info_pend_q <= 1'b1;
         end
         if (load) begin
            case (state_q)
               comp_pkg::CPL_TRL0: begin
                  rx_sof_n_o <= 1'b1;
                  state_q    <= comp_pkg::CPL_TRL1;
               end
               comp_pkg::CPL_TRL1: begin
                  rx_eof_n_o <= 1'b0;
                  state_q    <= comp_pkg::CPL_TRL2;
               end
               comp_pkg::CPL_TRL2: begin
                  rx_src_rdy_n_o <= 1'b1;
                  rx_eof_n_o     <= 1'b1;
                  state_q        <= comp_pkg::CPL_IDLE;
               end
               default: begin
                  if (take_payload) begin
                     rx_src_rdy_n_o <= 1'b0;
                     rx_sof_n_o     <= (state_q != comp_pkg::CPL_IDLE);
                     rx_sop_n_o     <= !sop_pend_q;
                     rx_eop_n_o     <= !rd_last_i;
                     sop_pend_q     <= rd_last_i;
                     state_q        <= comp_pkg::CPL_PAYLOAD;
                  end else if (take_trl0) begin
                     // sof lands here when the frame had no payload
                     rx_src_rdy_n_o <= 1'b0;
                     rx_sof_n_o     <= (state_q != comp_pkg::CPL_IDLE);
                     rx_sop_n_o     <= 1'b1;
                     rx_eop_n_o     <= 1'b1;
                     info_pend_q    <= 1'b0;
                     state_q        <= comp_pkg::CPL_TRL0;
                  end else begin
                     rx_src_rdy_n_o <= 1'b1;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_payload) begin
         rx_d_o   <= rd_data_i;
         rx_rem_o <= rd_rem_i;
      end else if (take_trl0) begin
         rx_d_o   <= trl0_word;
         rx_rem_o <= '0;
      end else if (load && state_q == comp_pkg::CPL_TRL0) begin
         rx_d_o <= cnt_q;
      end else if (load && state_q == comp_pkg::CPL_TRL1) begin
         rx_d_o <= {{(`COMP_DW - `COMP_TASK_W){1'b0}}, task_q};
      end
   end

endmodule

`default_nettype wire

/* verilog/comp_payload_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "comp_consts.svh"

module comp_payload_fifo (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     wr_en_i,
   input  wire comp_pkg::ll_word_t wr_data_i,
   input  wire comp_pkg::ll_rem_t  wr_rem_i,
   input  wire                     wr_last_i,
   input  wire                     rd_en_i,
   output logic                    full_o,
   output logic                    empty_o,
   output comp_pkg::ll_word_t      rd_data_o,
   output comp_pkg::ll_rem_t       rd_rem_o,
   output logic                    rd_last_o
);

   localparam int DEPTH = `COMP_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   comp_pkg::ll_word_t data_mem [DEPTH];
   comp_pkg::ll_rem_t  rem_mem  [DEPTH];
   logic               last_mem [DEPTH];

   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          do_wr;
   logic          do_rd;

   // guard both sides so a stray strobe cannot corrupt the pointers
   assign do_wr = wr_en_i && !full_o;
   assign do_rd = rd_en_i && !empty_o;

   assign full_o  = (count_q == CW'(DEPTH));
   assign empty_o = (count_q == '0);

   always_ff @(posedge clk) begin
      if (do_wr) begin
         data_mem[wr_ptr_q] <= wr_data_i;
         rem_mem[wr_ptr_q]  <= wr_rem_i;
         last_mem[wr_ptr_q] <= wr_last_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // head of queue, valid whenever empty_o is low
   assign rd_data_o = data_mem[rd_ptr_q];
   assign rd_rem_o  = rem_mem[rd_ptr_q];
   assign rd_last_o = last_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* verilog/comp_hdr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "comp_consts.svh"

module comp_hdr_decode (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire comp_pkg::ll_word_t tx_d_i,
   input  wire comp_pkg::ll_rem_t  tx_rem_i,
   input  wire                     tx_sof_n_i,
   input  wire                     tx_eof_n_i,
   input  wire                     tx_sop_n_i,
   input  wire                     tx_eop_n_i,
   input  wire                     tx_src_rdy_n_i,
   input  wire                     full_i,
   input  wire                     cpl_done_i,
   output logic                    tx_dst_rdy_n_o,
   output logic                    wr_en_o,
   output comp_pkg::ll_word_t      wr_data_o,
   output comp_pkg::ll_rem_t       wr_rem_o,
   output logic                    wr_last_o,
   output logic                    info_valid_o,
   output comp_pkg::comp_op_e      op_o,
   output logic                    status_o,
   output comp_pkg::byte_cnt_t     byte_cnt_o,
   output comp_pkg::task_idx_t     task_idx_o
);

   localparam int HCW = $clog2(`COMP_HDR_WORDS);
   localparam int VBW = $clog2(`COMP_REM_W + 1);

   comp_pkg::hdr_state_e state_q;
   logic [HCW-1:0]       hdr_cnt_q;
   comp_pkg::comp_op_e   op_q;
   comp_pkg::byte_cnt_t  len_q;
   comp_pkg::task_idx_t  task_q;
   comp_pkg::byte_cnt_t  byte_cnt_q;
   logic                 status_q;
   logic                 info_valid_q;
   logic                 tx_xfer;
   logic                 pay_xfer;
   logic                 is_copy;
   logic                 hdr_last;
   comp_pkg::ll_rem_t    eff_rem;
   comp_pkg::ll_word_t   masked_d;
   logic [VBW-1:0]       valid_bytes;
   comp_pkg::byte_cnt_t  cnt_nxt;
   comp_pkg::byte_cnt_t  cnt_final;

   // stall while the buffer is full or a completion is pending
   assign tx_dst_rdy_n_o = full_i || (state_q == comp_pkg::HDR_WAIT_CPL);
   assign tx_xfer  = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign pay_xfer = tx_xfer && (state_q == comp_pkg::HDR_PAYLOAD);
   assign is_copy  = (op_q == comp_pkg::OP_COPY);
   assign hdr_last = (hdr_cnt_q == HCW'(`COMP_HDR_WORDS - 1));

   // rem only means something on the eop word
   assign eff_rem = tx_eop_n_i ? '0 : tx_rem_i;

   // a set rem bit marks one invalid byte, counted from the low end
   always_comb begin
      masked_d    = tx_d_i;
      valid_bytes = VBW'(`COMP_REM_W);
      for (int b = 0; b < `COMP_REM_W; b++) begin
         if (eff_rem[b]) begin
            masked_d[8*b +: 8] = 8'h00;
            valid_bytes        = valid_bytes - 1'b1;
         end
      end
   end

   assign cnt_nxt   = (tx_sop_n_i ? byte_cnt_q : '0) + comp_pkg::byte_cnt_t'(valid_bytes);
   assign cnt_final = (pay_xfer && is_copy) ? cnt_nxt : byte_cnt_q;

   // only copy payload reaches the buffer
   assign wr_en_o   = pay_xfer && is_copy;
   assign wr_data_o = masked_d;
   assign wr_rem_o  = eff_rem;
   assign wr_last_o = !tx_eop_n_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q      <= comp_pkg::HDR_IDLE;
         hdr_cnt_q    <= '0;
         op_q         <= comp_pkg::OP_NONE;
         byte_cnt_q   <= '0;
         status_q     <= 1'b0;
         info_valid_q <= 1'b0;
      end else begin
         info_valid_q <= 1'b0;
         case (state_q)
            comp_pkg::HDR_IDLE: begin
               if (tx_xfer && !tx_sof_n_i) begin
                  hdr_cnt_q  <= HCW'(1);
                  byte_cnt_q <= '0;
                  state_q    <= comp_pkg::HDR_HEADER;
               end
            end
            comp_pkg::HDR_HEADER: begin
               if (tx_xfer) begin
                  hdr_cnt_q <= hdr_cnt_q + 1'b1;
                  if (hdr_cnt_q == HCW'(`COMP_HDR_FLAG_IDX)) begin
                     op_q <= comp_pkg::comp_op_e'(tx_d_i[`COMP_DW-1 -: 3]);
                  end
                  if (hdr_last) begin
                     state_q <= tx_eof_n_i ? comp_pkg::HDR_PAYLOAD : comp_pkg::HDR_WAIT_CPL;
                  end
               end
            end
            comp_pkg::HDR_PAYLOAD: begin
               byte_cnt_q <= cnt_final;
               if (tx_xfer && !tx_eof_n_i) begin
                  state_q <= comp_pkg::HDR_WAIT_CPL;
               end
            end
            default: begin
               if (cpl_done_i) begin
                  state_q <= comp_pkg::HDR_IDLE;
               end
            end
         endcase

         // end of frame, header-only frames end on word 6
         if (tx_xfer && !tx_eof_n_i &&
             ((state_q == comp_pkg::HDR_PAYLOAD) ||
              (state_q == comp_pkg::HDR_HEADER && hdr_last))) begin
            info_valid_q <= 1'b1;
            status_q     <= is_copy && (cnt_final == len_q);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_xfer && state_q == comp_pkg::HDR_HEADER) begin
         if (hdr_cnt_q == HCW'(`COMP_HDR_LEN_IDX)) begin
            len_q <= tx_d_i;
         end
         if (hdr_cnt_q == HCW'(`COMP_HDR_TASK_IDX)) begin
            task_q <= tx_d_i[`COMP_TASK_W-1:0];
         end
      end
   end

   assign info_valid_o = info_valid_q;
   assign op_o         = op_q;
   assign status_o     = status_q;
   assign byte_cnt_o   = byte_cnt_q;
   assign task_idx_o   = task_q;

endmodule

`default_nettype wire

/* verilog/comp_pkg.sv */
`default_nettype none

`include "comp_consts.svh"

package comp_pkg;

   typedef logic [`COMP_DW-1:0]    ll_word_t;
   typedef logic [`COMP_REM_W-1:0] ll_rem_t;
   typedef logic [`COMP_DW-1:0]    byte_cnt_t;
   typedef logic [`COMP_TASK_W-1:0] task_idx_t;

   // one-hot flag from header bits 31:29
   typedef enum logic [2:0] {
      OP_NONE   = 3'b000,
      OP_COPY   = 3'b001,
      OP_DECOMP = 3'b010,
      OP_COMP   = 3'b100
   } comp_op_e;

   // tx side
   typedef enum logic [1:0] {
      HDR_IDLE,
      HDR_HEADER,
      HDR_PAYLOAD,
      HDR_WAIT_CPL
   } hdr_state_e;

   // rx side, names the word held in the output register
   typedef enum logic [2:0] {
      CPL_IDLE,
      CPL_PAYLOAD,
      CPL_TRL0,
      CPL_TRL1,
      CPL_TRL2
   } cpl_state_e;

endpackage

`default_nettype wire

/* verilog/comp_consts.svh */
`ifndef COMP_CONSTS_SVH
`define COMP_CONSTS_SVH

// locallink data path
`define COMP_DW            32
`define COMP_REM_W         4

// request header layout, word index from sof
`define COMP_HDR_WORDS     7
`define COMP_HDR_FLAG_IDX  3
`define COMP_HDR_LEN_IDX   4
`define COMP_HDR_TASK_IDX  5

// task index sits in the low bits of its header word
`define COMP_TASK_W        10

// payload words held between tx and rx
`define COMP_FIFO_DEPTH    16

// status flag in trailer word 0, just under the op flag
`define COMP_STATUS_BIT    28

`endif
